// File: verilog/tft_cfg.svh
`ifndef TFT_CFG_SVH
`define TFT_CFG_SVH

// Panel geometry in pixels and lines, kept small for short frames
`define TFT_H_ACTIVE 16
`define TFT_H_BLANK 4
`define TFT_V_ACTIVE 6
`define TFT_V_BLANK 2

// clk cycles per pixel strobe, at least 4
`define TFT_PIXEL_DIV 8

// Pixel FIFO depth in words and its log2
`define TFT_FIFO_DEPTH_N 64
`define TFT_FIFO_AW 6

// Words per memory read request
`define TFT_BURST_LEN 8

// Framebuffer start, word address
`define TFT_FB_BASE 24'hf00000

`endif

// File: verilog/tft_pkg.sv
package tft_pkg;

	// Framebuffer word
	typedef struct packed {
		logic [4:0] red;
		logic [5:0] green;
		logic [4:0] blue;
	} rgb565_t;

	// Panel colour
	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb888_t;

	// Pixel strobe and blanking levels from the timing generator
	typedef struct packed {
		logic pixel_stb;
		logic hblank;
		logic vblank;
	} tft_sync_t;

	// Panel output
	typedef struct packed {
		rgb888_t rgb;
		logic    de;
	} tft_pixel_t;

	// Burst read request towards memory
	typedef struct packed {
		logic        req;
		logic [23:0] addr;
	} mem_req_t;

endpackage

// File: verilog/ram_dual.sv
`timescale 1ns/1ps
`include "tft_cfg.svh"

module ram_dual #(
	parameter int AW = `TFT_FIFO_AW
) (
	input  logic             clk,
	input  logic             n_reset,
	input  logic             wren,
	input  logic [AW-1:0]    wraddress,
	input  tft_pkg::rgb565_t data,
	input  logic [AW-1:0]    rdaddress,
	output tft_pkg::rgb565_t q
);

tft_pkg::rgb565_t mem [2**AW];

always_ff @(posedge clk) begin
	if (wren)
		mem[wraddress] <= data;
end

// Registered read, old word on a same-cycle collision
always_ff @(posedge clk, negedge n_reset) begin
	if (!n_reset)
		q <= '0;
	else
		q <= mem[rdaddress];
end

endmodule

// File: verilog/fifo_sync.sv
`timescale 1ns/1ps
`include "tft_cfg.svh"

module fifo_sync #(
	parameter int AW = `TFT_FIFO_AW
) (
	input  logic          clk,
	input  logic          n_reset,
	input  logic          flush,
	input  logic          wrreq,
	input  logic          rdack,
	output logic [AW-1:0] head,
	output logic [AW-1:0] tail,
	output logic          empty,
	output logic          full,
	output logic          overrun
);

// Pointers carry one extra wrap bit
logic [AW:0] head_q;
logic [AW:0] tail_q;

assign head = head_q[AW-1:0];
assign tail = tail_q[AW-1:0];

assign empty = head_q == tail_q;
assign full  = (head_q[AW] != tail_q[AW]) && (head_q[AW-1:0] == tail_q[AW-1:0]);

// Write side
always_ff @(posedge clk, negedge n_reset) begin
	if (!n_reset)
		head_q <= '0;
	else if (flush)
		head_q <= '0;
	else if (wrreq)
		head_q <= head_q + 1'b1;
end

// Read side
always_ff @(posedge clk, negedge n_reset) begin
	if (!n_reset)
		tail_q <= '0;
	else if (flush)
		tail_q <= '0;
	else if (rdack)
		tail_q <= tail_q + 1'b1;
end

// Sticky until the next flush
always_ff @(posedge clk, negedge n_reset) begin
	if (!n_reset)
		overrun <= 1'b0;
	else if (flush)
		overrun <= 1'b0;
	else if (wrreq && full)
		overrun <= 1'b1;
end

// The fetch level counter must keep the writer from ever filling past the top
a_no_overrun: assert property (@(posedge clk) disable iff (!n_reset) !overrun)
	else $error("fifo_sync: write while full");

endmodule

// File: verilog/tft_timing.sv
`timescale 1ns/1ps
`include "tft_cfg.svh"

module tft_timing (
	input  logic               clk,
	input  logic               n_reset,
	output tft_pkg::tft_sync_t sync
);

localparam int H_TOTAL = `TFT_H_ACTIVE + `TFT_H_BLANK;
localparam int V_TOTAL = `TFT_V_ACTIVE + `TFT_V_BLANK;
localparam int DW = $clog2(`TFT_PIXEL_DIV);
localparam int HW = $clog2(H_TOTAL);
localparam int VW = $clog2(V_TOTAL);

logic [DW-1:0] div_cnt;
logic          div_end;
logic [HW-1:0] h_cnt;
logic [HW-1:0] h_next;
logic [VW-1:0] v_cnt;
logic [VW-1:0] v_next;
logic          pixel_stb;
logic          hblank;
logic          vblank;

// Last clk of each pixel period
assign div_end = div_cnt == DW'(`TFT_PIXEL_DIV - 1);

// Position of the next pixel
always_comb begin
	h_next = h_cnt + 1'b1;
	v_next = v_cnt;
	if (h_cnt == HW'(H_TOTAL - 1)) begin
		h_next = '0;
		if (v_cnt == VW'(V_TOTAL - 1))
			v_next = '0;
		else
			v_next = v_cnt + 1'b1;
	end
end

// Pixel clock divider
always_ff @(posedge clk, negedge n_reset) begin
	if (!n_reset) begin
		div_cnt   <= '0;
		pixel_stb <= 1'b0;
	end else begin
		pixel_stb <= div_end;
		if (div_end)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end
end

// Counters and blanking move together with the strobe,
// so the levels are valid in the strobe cycle itself.
// Blank pixels lead each line so the FIFO refills between vblank and the first pop
// Out of reset we sit on the first blank line.
always_ff @(posedge clk, negedge n_reset) begin
	if (!n_reset) begin
		h_cnt  <= '0;
		v_cnt  <= VW'(`TFT_V_ACTIVE);
		hblank <= 1'b1;
		vblank <= 1'b1;
	end else if (div_end) begin
		h_cnt  <= h_next;
		v_cnt  <= v_next;
		hblank <= h_next < HW'(`TFT_H_BLANK);
		vblank <= v_next >= VW'(`TFT_V_ACTIVE);
	end
end

assign sync = '{pixel_stb: pixel_stb, hblank: hblank, vblank: vblank};

endmodule

// File: verilog/tft_fetch.sv
`timescale 1ns/1ps
`include "tft_cfg.svh"

module tft_fetch (
	input  logic                clk,
	input  logic                n_reset,
	input  tft_pkg::tft_sync_t  sync,
	output tft_pkg::mem_req_t   mem,
	input  logic                rdy,
	input  logic                ifrdy,
	input  tft_pkg::rgb565_t    data,
	output tft_pkg::tft_pixel_t pixel,
	output logic                underrun
);

localparam int AW = `TFT_FIFO_AW;
localparam int LW = AW + 1;
// Two requests may land before req sees the new level
localparam int REQ_LIMIT = `TFT_FIFO_DEPTH_N - 2 * `TFT_BURST_LEN;
localparam logic [23:0] FB_BASE = `TFT_FB_BASE;

logic             flush;
logic             req;
logic             accept;
logic             pop;
logic             rdack;
logic             empty;
logic             empty_d;
logic             avail;
logic             full;
logic [AW-1:0]    head;
logic [AW-1:0]    tail;
logic [LW-1:0]    level;
logic [19:0]      addr_ofs;
tft_pkg::rgb565_t fifo_q;

function automatic tft_pkg::rgb888_t expand(tft_pkg::rgb565_t c);
	return '{red: {c.red, 3'b000}, green: {c.green, 2'b00}, blue: {c.blue, 3'b000}};
endfunction

assign accept = req & rdy;
assign pop    = sync.pixel_stb & ~sync.hblank & ~sync.vblank;

// A word just written needs one more cycle to show on the RAM output
assign avail = ~empty & ~empty_d;
assign rdack = pop & avail;

// Frame restart, starts asserted so the first frame is clean
always_ff @(posedge clk, negedge n_reset) begin
	if (!n_reset) begin
		flush   <= 1'b1;
		empty_d <= 1'b1;
	end else begin
		flush   <= sync.vblank;
		empty_d <= empty;
	end
end

// Words held plus words promised by accepted bursts
always_ff @(posedge clk, negedge n_reset) begin
	if (!n_reset)
		level <= '0;
	else if (flush)
		level <= '0;
	else
		level <= level + (accept ? LW'(`TFT_BURST_LEN) : LW'(0)) - (rdack ? LW'(1) : LW'(0));
end

// Request generator
always_ff @(posedge clk, negedge n_reset) begin
	if (!n_reset)
		req <= 1'b0;
	else
		req <= ~flush & ~sync.vblank & (level < LW'(REQ_LIMIT));
end

// Burst address, offset from the framebuffer base
always_ff @(posedge clk, negedge n_reset) begin
	if (!n_reset)
		addr_ofs <= '0;
	else if (flush)
		addr_ofs <= '0;
	else if (accept)
		addr_ofs <= addr_ofs + 20'(`TFT_BURST_LEN);
end

assign mem = '{req: req, addr: {FB_BASE[23:20], FB_BASE[19:0] + addr_ofs}};

fifo_sync #(.AW(AW)) fifo_i (
	.clk     (clk),
	.n_reset (n_reset),
	.flush   (flush),
	.wrreq   (ifrdy),
	.rdack   (rdack),
	.head    (head),
	.tail    (tail),
	.empty   (empty),
	.full    (full),
	.overrun ()
);

ram_dual #(.AW(AW)) ram_i (
	.clk       (clk),
	.n_reset   (n_reset),
	.wren      (ifrdy),
	.wraddress (head),
	.data      (data),
	.rdaddress (tail),
	.q         (fifo_q)
);

// Panel register, updated once per pixel period
always_ff @(posedge clk, negedge n_reset) begin
	if (!n_reset) begin
		pixel    <= '0;
		underrun <= 1'b0;
	end else begin
		underrun <= pop & ~avail;
		if (sync.pixel_stb) begin
			pixel.de  <= pop;
			pixel.rgb <= pop ? expand(fifo_q) : '0;
		end
	end
end

// Memory must never deliver beyond what the level counter allowed
a_no_beat_full: assert property (@(posedge clk) disable iff (!n_reset) !(ifrdy && full))
	else $error("tft_fetch: burst beat while FIFO full");

a_level_max: assert property (
	@(posedge clk) disable iff (!n_reset) level <= LW'(`TFT_FIFO_DEPTH_N))
	else $error("tft_fetch: level above FIFO depth");

endmodule

// File: verilog/tft_top.sv
`timescale 1ns/1ps

module tft_top (
	input  logic                clk,
	input  logic                n_reset,
	// Memory side
	output tft_pkg::mem_req_t   mem,
	input  logic                rdy,
	input  logic                ifrdy,
	input  tft_pkg::rgb565_t    data,
	// Panel side
	output tft_pkg::tft_pixel_t pixel,
	output tft_pkg::tft_sync_t  sync,
	output logic                underrun
);

tft_timing timing_i (
	.clk     (clk),
	.n_reset (n_reset),
	.sync    (sync)
);

tft_fetch fetch_i (
	.clk      (clk),
	.n_reset  (n_reset),
	.sync     (sync),
	.mem      (mem),
	.rdy      (rdy),
	.ifrdy    (ifrdy),
	.data     (data),
	.pixel    (pixel),
	.underrun (underrun)
);

endmodule

// File: test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
	parameter realtime PERIOD       = 100ns,
	parameter int      RESET_CYCLES = 2
) (
	output logic clk,
	output logic n_reset
);

initial begin
	clk     = 1'b0;
	n_reset = 1'b0;
	repeat (RESET_CYCLES) @(posedge clk);
	// Release like any other input, shortly after the edge
	#10;
	n_reset = 1'b1;
end

always #(PERIOD / 2) clk = ~clk;

endmodule

// File: test/tb_tft_top.sv
`timescale 1ns/1ps
`include "tft_cfg.svh"

module tb_tft_top;

localparam int FRAME_PIXELS = `TFT_H_ACTIVE * `TFT_V_ACTIVE;
localparam int FRAMES       = 6;
localparam int STALL_FRAME  = 5;
localparam int RUN_LIMIT    = 12000;
localparam logic [23:0] FB_BASE = `TFT_FB_BASE;

logic                clk;
logic                n_reset;
tft_pkg::mem_req_t   mem;
logic                rdy;
logic                ifrdy;
tft_pkg::rgb565_t    data;
tft_pkg::tft_pixel_t pixel;
tft_pkg::tft_sync_t  sync;
logic                underrun;

int checks;
int errors;
bit timed_out;

// Word addresses of burst beats the memory still owes
logic [23:0] beat_q[$];

tb_clock clock_i (
	.clk     (clk),
	.n_reset (n_reset)
);

tft_top dut_i (
	.clk      (clk),
	.n_reset  (n_reset),
	.mem      (mem),
	.rdy      (rdy),
	.ifrdy    (ifrdy),
	.data     (data),
	.pixel    (pixel),
	.sync     (sync),
	.underrun (underrun)
);

// Framebuffer contents
function automatic logic [15:0] mem_word(input logic [23:0] addr);
	logic [39:0] prod;
	prod = addr * 40'h9e37;
	return prod[15:0];
endfunction

// RGB565 to RGB888, low bits zero
function automatic logic [23:0] rgb888_of(input logic [15:0] w);
	return {w[15:11], 3'b000, w[10:5], 2'b00, w[4:0], 3'b000};
endfunction

task automatic check(input bit ok, input string msg);
	checks++;
	assert (ok) else begin
		errors++;
		$display("ERROR %0t: %s", $time, msg);
	end
endtask

initial begin
	int                  wait_cnt;
	int                  cycles;
	int                  frame_idx;
	int                  frames_done;
	int                  de_count;
	int                  pop_count;
	int                  underrun_count;
	int                  exp_ofs;
	int                  stb_gap;
	bit                  stall;
	bit                  in_frame;
	bit                  stb_prev;
	bit                  pop_prev;
	bit                  vblank_prev;
	bit                  hblank_prev;
	tft_pkg::tft_pixel_t pixel_prev;
	logic [23:0]         addr;
	logic [15:0]         exp_word;

	$timeformat(-9, 0, " ns", 0);
	void'($urandom(32'h5eb0));
	rdy       = 1'b0;
	ifrdy     = 1'b0;
	data      = '0;
	checks    = 0;
	errors    = 0;
	timed_out = 1'b0;

	// Outputs stay quiet while reset is held
	wait_cnt = 0;
	do begin
		@(posedge clk);
		#5;
		if (!n_reset)
			check(!mem.req && !pixel.de && !underrun, "req, de or underrun high in reset");
		wait_cnt++;
	end while (!n_reset && wait_cnt < 10);
	if (!n_reset) begin
		$display("Timeout: reset was never released");
		timed_out = 1'b1;
	end

	cycles         = 0;
	frame_idx      = 0;
	frames_done    = 0;
	de_count       = 0;
	pop_count      = 0;
	underrun_count = 0;
	exp_ofs        = 0;
	stb_gap        = -1;
	stall          = 1'b0;
	in_frame       = 1'b0;
	stb_prev       = 1'b0;
	pop_prev       = 1'b0;
	vblank_prev    = 1'b1;
	hblank_prev    = sync.hblank;
	pixel_prev     = pixel;

	while (!timed_out && frames_done < FRAMES) begin
		@(posedge clk);
		#10;

		// Strobe period and blanking levels follow the pixel divider
		if (sync.pixel_stb) begin
			if (stb_gap >= 0)
				check(stb_gap == `TFT_PIXEL_DIV,
					$sformatf("pixel strobe after %0d cycles", stb_gap));
			stb_gap = 0;
		end else begin
			check(sync.hblank == hblank_prev && sync.vblank == vblank_prev,
				"blanking changed between strobes");
		end
		if (stb_gap >= 0)
			stb_gap++;

		// Panel register shows the result of the previous strobe
		check(!underrun || (stb_prev && pixel.de), "underrun outside a due pixel");
		if (!stb_prev)
			check(pixel == pixel_prev, "pixel output changed between strobes");
		if (stb_prev) begin
			check(pixel.de == pop_prev,
				$sformatf("de is %0b, expected %0b", pixel.de, pop_prev));
			if (pixel.de) begin
				de_count++;
				if (underrun) begin
					underrun_count++;
					// Fast memory never starves the panel
					check(stall,
						$sformatf("underrun at pixel %0d of frame %0d", de_count, frame_idx));
				end else begin
					exp_word = mem_word(FB_BASE + 24'(pop_count));
					check(pixel.rgb == rgb888_of(exp_word),
						$sformatf("pixel %0d of frame %0d is %06h, expected %06h",
							pop_count, frame_idx, pixel.rgb, rgb888_of(exp_word)));
					pop_count++;
				end
			end
		end

		// End of the active part of a frame
		if (sync.vblank && !vblank_prev) begin
			if (in_frame) begin
				check(de_count == FRAME_PIXELS,
					$sformatf("frame %0d had %0d pixels, expected %0d",
						frame_idx, de_count, FRAME_PIXELS));
				if (stall)
					check(underrun_count > 0,
						$sformatf("no underrun in stalled frame %0d", frame_idx));
				frames_done++;
			end
			exp_ofs = 0;
		end
		if (!sync.vblank && vblank_prev) begin
			frame_idx++;
			in_frame       = 1'b1;
			stall          = frame_idx == STALL_FRAME;
			de_count       = 0;
			pop_count      = 0;
			underrun_count = 0;
		end

		// Memory model, beats with random gaps
		if (beat_q.size() > 0 && $urandom_range(3) != 0) begin
			addr  = beat_q.pop_front();
			ifrdy = 1'b1;
			data  = mem_word(addr);
		end else begin
			ifrdy = 1'b0;
			data  = '0;
		end
		rdy = stall ? 1'b0 : ($urandom_range(7) != 0);
		if (mem.req && rdy) begin
			check(mem.addr[23:20] == 4'hf,
				$sformatf("request address %06h left the framebuffer", mem.addr));
			// A request taken as vblank begins still belongs to the old frame
			if (!sync.vblank || vblank_prev) begin
				check(mem.addr == FB_BASE + 24'(exp_ofs),
					$sformatf("request address %06h, expected %06h",
						mem.addr, FB_BASE + 24'(exp_ofs)));
				exp_ofs += `TFT_BURST_LEN;
			end
			for (int i = 0; i < `TFT_BURST_LEN; i++)
				beat_q.push_back(mem.addr + 24'(i));
		end

		stb_prev    = sync.pixel_stb;
		pop_prev    = sync.pixel_stb & ~sync.hblank & ~sync.vblank;
		vblank_prev = sync.vblank;
		hblank_prev = sync.hblank;
		pixel_prev  = pixel;

		cycles++;
		if (cycles >= RUN_LIMIT) begin
			$display("Timeout: only %0d of %0d frames completed", frames_done, FRAMES);
			timed_out = 1'b1;
		end
	end

	$display("Checks: %0d, errors: %0d", checks, errors);
	if (errors == 0 && !timed_out)
		$display("Simulation finished: PASS");
	else
		$display("Simulation finished: FAIL");
	$finish;
end

endmodule

// File: build.f
+incdir+verilog
verilog/tft_pkg.sv
verilog/ram_dual.sv
verilog/fifo_sync.sv
verilog/tft_timing.sv
verilog/tft_fetch.sv
verilog/tft_top.sv
test/tb_clock.sv
test/tb_tft_top.sv
